/* Bender.yml */
package:
  name: alu_apb

sources:
  # Packages first, then the RTL bottom up
  - files:
      - hw/aluPkg.sv
      - hw/apbPkg.sv
      - hw/claAdder.sv
      - hw/barrelShifter.sv
      - hw/alu.sv
      - hw/apbAluRegs.sv
      - hw/aluApbTop.sv

  # Testbench
  - target: test
    files:
      - verification/aluApbTb.sv

/* files.f */
hw/aluPkg.sv
hw/apbPkg.sv
hw/claAdder.sv
hw/barrelShifter.sv
hw/alu.sv
hw/apbAluRegs.sv
hw/aluApbTop.sv
verification/aluApbTb.sv

/* hw/alu.sv */
`timescale 1ns/1ps

module alu #(
    parameter int DataWidth = 16
) (
    input  aluPkg::aluCmdT  cmd,
    output aluPkg::aluRespT resp
);
    aluPkg::wordT      opA;
    aluPkg::wordT      opB;
    aluPkg::wordT      aMod;
    aluPkg::wordT      bMod;
    aluPkg::wordT      sum;
    aluPkg::wordT      xorRes;
    aluPkg::wordT      andnRes;
    aluPkg::wordT      shiftRes;
    aluPkg::wordT      result;
    aluPkg::shiftModeT shiftMode;
    logic              invA;
    logic              invB;
    logic              cin;
    logic              cout;
    logic              equal;
    logic              overflow;
    logic              lessThan;
    logic              zero;
    logic              negative;
    logic              err;

    assign opA = cmd.opA;
    assign opB = cmd.opB;

    // Operand inversion and carry in for the adder
    always_comb begin
        invA = 1'b0;
        invB = 1'b0;
        cin  = 1'b0;
        case (cmd.opcode)
            aluPkg::SUBI: begin
                invA = 1'b1;  // opB - opA
                cin  = 1'b1;
            end
            aluPkg::ANDNI: invB = 1'b1;
            aluPkg::SEQ, aluPkg::SLT, aluPkg::SLE: begin
                invB = 1'b1;  // opA - opB
                cin  = 1'b1;
            end
            aluPkg::ARITHREG: begin
                invA = (cmd.funct == aluPkg::FUNCT_SUB);
                cin  = (cmd.funct == aluPkg::FUNCT_SUB);
                invB = (cmd.funct == aluPkg::FUNCT_ANDN);
            end
            default: begin
            end
        endcase
    end

    assign aMod = invA ? ~opA : opA;
    assign bMod = invB ? ~opB : opB;

    claAdder #(.DataWidth(DataWidth)) adder_i (
        .a    (aMod),
        .b    (bMod),
        .cin  (cin),
        .sum  (sum),
        .cout (cout)
    );

    assign xorRes  = opA ^ opB;
    assign andnRes = aMod & bMod;

    // Immediate shifts carry the mode in the low opcode bits
    assign shiftMode = aluPkg::shiftModeT'((cmd.opcode == aluPkg::SHIFTREG) ?
                                           cmd.funct : cmd.opcode[1:0]);

    barrelShifter #(.DataWidth(DataWidth)) shifter_i (
        .data    (opA),
        .amount  (opB[3:0]),
        .mode    (shiftMode),
        .reverse (cmd.opcode == aluPkg::BTR),
        .result  (shiftRes)
    );

    // Signed compare on opA - opB
    assign equal    = (sum == '0);
    assign overflow = (opA[15] ^ opB[15]) & (sum[15] ^ opA[15]);
    assign lessThan = sum[15] ^ overflow;

    always_comb begin
        result = '0;
        err    = 1'b0;
        case (cmd.opcode)
            aluPkg::HALT, aluPkg::NOP, aluPkg::SIIC, aluPkg::RTI: result = '0;
            aluPkg::ADDI, aluPkg::SUBI, aluPkg::ST, aluPkg::LD, aluPkg::STU,
            aluPkg::BEQZ, aluPkg::BNEZ, aluPkg::BLTZ, aluPkg::BGEZ,
            aluPkg::J, aluPkg::JR, aluPkg::JAL, aluPkg::JALR: result = sum;
            aluPkg::XORI:  result = xorRes;
            aluPkg::ANDNI: result = andnRes;
            aluPkg::ROLI, aluPkg::SLLI, aluPkg::RORI, aluPkg::SRLI,
            aluPkg::SHIFTREG, aluPkg::BTR: result = shiftRes;
            aluPkg::ARITHREG: begin
                case (cmd.funct)
                    aluPkg::FUNCT_XOR:  result = xorRes;
                    aluPkg::FUNCT_ANDN: result = andnRes;
                    default:            result = sum;  // ADD and SUB
                endcase
            end
            aluPkg::SEQ:  result = aluPkg::wordT'(equal);
            aluPkg::SLT:  result = aluPkg::wordT'(lessThan);
            aluPkg::SLE:  result = aluPkg::wordT'(lessThan | equal);
            aluPkg::SCO:  result = aluPkg::wordT'(cout);
            aluPkg::LBI:  result = opB;
            aluPkg::SLBI: result = {opA[7:0], 8'h00} | opB;
            default: begin
                result = '0;
                err    = 1'b1;  // Undefined opcode
            end
        endcase
    end

    // Flags follow the final result
    assign zero     = (result == '0);
    assign negative = result[15] & ~zero;

    assign resp.result         = result;
    assign resp.flags.zero     = zero;
    assign resp.flags.negative = negative;
    assign resp.flags.positive = ~(zero | negative);
    assign resp.flags.err      = err;

endmodule

/* hw/aluApbTop.sv */
`timescale 1ns/1ps

module aluApbTop #(
    parameter int DataWidth = 16
) (
    input  logic            clk,
    input  logic            rst,
    input  apbPkg::apbReqT  apbReq,
    output apbPkg::apbRespT apbResp
);
    aluPkg::aluCmdT  aluCmd;   // Registered command into the ALU
    aluPkg::aluRespT aluResp;  // Combinational ALU output

    apbAluRegs regs_i (
        .clk     (clk),
        .rst     (rst),
        .req     (apbReq),
        .resp    (apbResp),
        .cmd     (aluCmd),
        .aluResp (aluResp)
    );

    alu #(
        .DataWidth (DataWidth)
    ) alu_i (
        .cmd  (aluCmd),
        .resp (aluResp)
    );

endmodule

/* hw/aluPkg.sv */
package aluPkg;

    typedef logic [15:0] wordT;  // ALU data word
    typedef logic [1:0]  functT; // Register-format function field

    typedef enum logic [4:0] {
        HALT     = 5'b00000,
        NOP      = 5'b00001,
        SIIC     = 5'b00010,
        RTI      = 5'b00011,
        J        = 5'b00100,
        JR       = 5'b00101,
        JAL      = 5'b00110,
        JALR     = 5'b00111,
        ADDI     = 5'b01000,
        SUBI     = 5'b01001,
        XORI     = 5'b01010,
        ANDNI    = 5'b01011,
        BEQZ     = 5'b01100,
        BNEZ     = 5'b01101,
        BLTZ     = 5'b01110,
        BGEZ     = 5'b01111,
        ST       = 5'b10000,
        LD       = 5'b10001,
        SLBI     = 5'b10010,
        STU      = 5'b10011,
        ROLI     = 5'b10100,
        SLLI     = 5'b10101,
        RORI     = 5'b10110,
        SRLI     = 5'b10111,
        LBI      = 5'b11000,
        BTR      = 5'b11001,
        SHIFTREG = 5'b11010, // ROL, SLL, ROR, SRL by funct
        ARITHREG = 5'b11011, // ADD, SUB, XOR, ANDN by funct
        SEQ      = 5'b11100,
        SLT      = 5'b11101,
        SLE      = 5'b11110,
        SCO      = 5'b11111
    } opcodeT;

    // Members of the arithmetic register group
    localparam functT FUNCT_ADD  = 2'b00;
    localparam functT FUNCT_SUB  = 2'b01;
    localparam functT FUNCT_XOR  = 2'b10;
    localparam functT FUNCT_ANDN = 2'b11;

    // Same order as the shift group funct and the low opcode bits of ROLI..SRLI
    typedef enum logic [1:0] {
        ROL = 2'b00,
        SLL = 2'b01,
        ROR = 2'b10,
        SRL = 2'b11
    } shiftModeT;

    typedef struct packed {
        logic zero;
        logic positive;
        logic negative;
        logic err;
    } aluFlagsT;

    typedef struct packed {
        wordT   opA;
        wordT   opB;
        opcodeT opcode;
        functT  funct;
    } aluCmdT;

    typedef struct packed {
        wordT     result;
        aluFlagsT flags;
    } aluRespT;

endpackage

/* hw/apbAluRegs.sv */
`timescale 1ns/1ps

module apbAluRegs (
    input  logic             clk,
    input  logic             rst,
    input  apbPkg::apbReqT   req,
    output apbPkg::apbRespT  resp,
    output aluPkg::aluCmdT   cmd,
    input  aluPkg::aluRespT  aluResp
);
    aluPkg::wordT    opAReg;
    aluPkg::wordT    opBReg;
    aluPkg::opcodeT  opcodeReg;
    aluPkg::functT   functReg;
    aluPkg::aluRespT resultReg;
    logic            launch;   // High the cycle after a command write
    logic            done;
    logic            access;
    logic            wrAccess;
    logic            mapped;
    logic            illegal;

    assign access   = req.psel & req.penable;
    assign wrAccess = access & req.pwrite;

    assign mapped  = (req.paddr == apbPkg::OPERAND_ADDR) ||
                     (req.paddr == apbPkg::COMMAND_ADDR) ||
                     (req.paddr == apbPkg::RESULT_ADDR);
    assign illegal = !mapped ||
                     (req.pwrite && req.paddr == apbPkg::RESULT_ADDR) ||
                     (!req.pwrite && req.paddr == apbPkg::COMMAND_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            opAReg    <= '0;
            opBReg    <= '0;
            opcodeReg <= aluPkg::NOP;
            functReg  <= '0;
            resultReg <= '0;
            launch    <= 1'b0;
            done      <= 1'b0;
        end else begin
            launch <= 1'b0;
            if (wrAccess && req.paddr == apbPkg::OPERAND_ADDR) begin
                opAReg <= req.pwdata[15:0];
                opBReg <= req.pwdata[31:16];
                done   <= 1'b0;
            end else if (wrAccess && req.paddr == apbPkg::COMMAND_ADDR) begin
                opcodeReg <= aluPkg::opcodeT'(req.pwdata[4:0]);
                functReg  <= req.pwdata[6:5];
                launch    <= 1'b1;
                done      <= 1'b0;
            end else if (launch) begin
                resultReg <= aluResp;  // ALU has settled on the new command
                done      <= 1'b1;
            end
        end
    end

    assign cmd.opA    = opAReg;
    assign cmd.opB    = opBReg;
    assign cmd.opcode = opcodeReg;
    assign cmd.funct  = functReg;

    // Read mux
    always_comb begin
        resp.prdata = '0;
        case (req.paddr)
            apbPkg::OPERAND_ADDR: resp.prdata = {opBReg, opAReg};
            apbPkg::RESULT_ADDR: begin
                resp.prdata[15:0]                 = resultReg.result;
                resp.prdata[apbPkg::RES_ZERO_BIT] = resultReg.flags.zero;
                resp.prdata[apbPkg::RES_POS_BIT]  = resultReg.flags.positive;
                resp.prdata[apbPkg::RES_NEG_BIT]  = resultReg.flags.negative;
                resp.prdata[apbPkg::RES_ERR_BIT]  = resultReg.flags.err;
                resp.prdata[apbPkg::RES_DONE_BIT] = done;
            end
            default: resp.prdata = '0;
        endcase
    end

    assign resp.pready  = 1'b1;  // Zero wait states
    assign resp.pslverr = access & illegal;

endmodule

/* hw/apbPkg.sv */
package apbPkg;

    typedef logic [11:0] addrT;    // APB byte address
    typedef logic [31:0] apbDataT; // APB data bus

    // Register map
    localparam addrT OPERAND_ADDR = 12'h000; // opB[31:16], opA[15:0]
    localparam addrT COMMAND_ADDR = 12'h004; // funct[6:5], opcode[4:0], write only
    localparam addrT RESULT_ADDR  = 12'h008; // Result and flags, read only

    // Field positions in the result register
    localparam int RES_ZERO_BIT = 16;
    localparam int RES_POS_BIT  = 17;
    localparam int RES_NEG_BIT  = 18;
    localparam int RES_ERR_BIT  = 19;
    localparam int RES_DONE_BIT = 31;

    typedef struct packed {
        logic    psel;
        logic    penable;
        logic    pwrite;
        addrT    paddr;
        apbDataT pwdata;
    } apbReqT;

    typedef struct packed {
        apbDataT prdata;
        logic    pready;
        logic    pslverr;
    } apbRespT;

endpackage

/* hw/barrelShifter.sv */
`timescale 1ns/1ps

module barrelShifter #(
    parameter int DataWidth = 16
) (
    input  logic [DataWidth-1:0] data,
    input  logic [3:0]           amount,
    input  aluPkg::shiftModeT    mode,
    input  logic                 reverse,
    output logic [DataWidth-1:0] result
);
    logic [DataWidth-1:0] stage [5]; // stage[k] has seen amount bits below k
    logic [DataWidth-1:0] reversed;
    logic                 left;
    logic                 rotate;

    assign left   = (mode == aluPkg::ROL) || (mode == aluPkg::SLL);
    assign rotate = (mode == aluPkg::ROL) || (mode == aluPkg::ROR);

    assign stage[0] = data;

    // Stages move by 1, 2, 4 and 8
    for (genvar k = 0; k < 4; k++) begin : genStage
        localparam int Dist = 1 << k;

        logic [DataWidth-1:0] shifted;
        logic [DataWidth-1:0] wrapped;

        assign shifted = left ? (stage[k] << Dist) : (stage[k] >> Dist);
        // Bits pushed off the far end, only kept when rotating
        assign wrapped = left ? (stage[k] >> (DataWidth - Dist))
                              : (stage[k] << (DataWidth - Dist));

        always_comb begin
            if (!amount[k]) begin
                stage[k+1] = stage[k];
            end else if (rotate) begin
                stage[k+1] = shifted | wrapped;
            end else begin
                stage[k+1] = shifted;  // Zero fill
            end
        end
    end

    // BTR mirror
    always_comb begin
        for (int i = 0; i < DataWidth; i++) begin
            reversed[i] = data[DataWidth-1-i];
        end
    end

    assign result = reverse ? reversed : stage[4];

endmodule

/* hw/claAdder.sv */
`timescale 1ns/1ps

module claAdder #(
    parameter int DataWidth = 16
) (
    input  logic [DataWidth-1:0] a,
    input  logic [DataWidth-1:0] b,
    input  logic                 cin,
    output logic [DataWidth-1:0] sum,
    output logic                 cout
);
    localparam int Groups = DataWidth / 4;

    logic [DataWidth-1:0] gen;
    logic [DataWidth-1:0] prop;
    logic [DataWidth-1:0] carry;  // Carry into each bit
    logic [Groups-1:0]    grpGen;
    logic [Groups-1:0]    grpProp;
    logic [Groups:0]      grpCarry;

    assign gen  = a & b;
    assign prop = a ^ b;

    for (genvar i = 0; i < Groups; i++) begin : genGroup
        logic [3:0] g;
        logic [3:0] p;
        logic       c;

        assign g = gen[4*i +: 4];
        assign p = prop[4*i +: 4];
        assign c = grpCarry[i];

        // Bit carries inside the group
        assign carry[4*i]     = c;
        assign carry[4*i + 1] = g[0] | (p[0] & c);
        assign carry[4*i + 2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c);
        assign carry[4*i + 3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                              | (p[2] & p[1] & p[0] & c);

        assign grpGen[i]  = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                          | (p[3] & p[2] & p[1] & g[0]);
        assign grpProp[i] = &p;
    end

    // Second lookahead level, each group carry flattened from cin
    always_comb begin
        logic term;
        logic prod;
        grpCarry[0] = cin;
        for (int i = 0; i < Groups; i++) begin
            term = grpGen[i];
            prod = grpProp[i];
            for (int j = i - 1; j >= 0; j--) begin
                term = term | (prod & grpGen[j]);
                prod = prod & grpProp[j];
            end
            grpCarry[i+1] = term | (prod & cin);
        end
    end

    assign sum  = prop ^ carry;
    assign cout = grpCarry[Groups];

endmodule

/* verification/aluApbTb.sv */
`timescale 1ns/1ps

module aluApbTb;

    localparam int ClkPeriod    = 20;
    localparam int RandomCmds   = 400;
    localparam int JunkCmds     = 100;
    localparam int DirectedCmds = 42;    // Corners, do-nothing group, bus error and done tests
    localparam int CmdTx        = 3;     // Operand write, command write, result read
    // Commands plus the single reset, bus error and done test accesses
    localparam int Transactions = CmdTx * (RandomCmds + JunkCmds + DirectedCmds) + 9;
    localparam int CyclesPerTx  = 3;     // Setup, access, idle
    localparam int PollLimit    = 8;

    logic            clk;
    logic            rst;
    apbPkg::apbReqT  apbReq;
    apbPkg::apbRespT apbResp;
    int              errCount;
    int              testsPassed;
    int              testsFailed;
    int              testStartErr;
    int              seed;

    aluApbTop #(.DataWidth(16)) dut_i (
        .clk     (clk),
        .rst     (rst),
        .apbReq  (apbReq),
        .apbResp (apbResp)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Watchdog sized from the transaction budget
    initial begin
        #(Transactions * CyclesPerTx * ClkPeriod + 50 * ClkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    // Reference model of the ALU rules
    function automatic aluPkg::aluRespT expectedResp(input aluPkg::wordT a,
                                                     input aluPkg::wordT b,
                                                     input logic [4:0] op,
                                                     input logic [1:0] fn);
        aluPkg::aluRespT r;
        logic [31:0]     dbl;
        logic [16:0]     wide;
        logic [1:0]      mode;
        logic [3:0]      n;
        int              i;
        r    = '0;
        n    = b[3:0];
        wide = {1'b0, a} + {1'b0, b};
        mode = (op == aluPkg::SHIFTREG) ? fn : op[1:0];  // 00 rol, 01 sll, 10 ror, 11 srl
        case (aluPkg::opcodeT'(op))
            aluPkg::HALT, aluPkg::NOP, aluPkg::SIIC, aluPkg::RTI: r.result = '0;
            aluPkg::ADDI, aluPkg::ST, aluPkg::LD, aluPkg::STU,
            aluPkg::BEQZ, aluPkg::BNEZ, aluPkg::BLTZ, aluPkg::BGEZ,
            aluPkg::J, aluPkg::JR, aluPkg::JAL, aluPkg::JALR: r.result = a + b;
            aluPkg::SUBI:  r.result = b - a;
            aluPkg::XORI:  r.result = a ^ b;
            aluPkg::ANDNI: r.result = a & ~b;
            aluPkg::ARITHREG: begin
                case (fn)
                    2'b00:   r.result = a + b;
                    2'b01:   r.result = b - a;
                    2'b10:   r.result = a ^ b;
                    default: r.result = a & ~b;
                endcase
            end
            aluPkg::ROLI, aluPkg::SLLI, aluPkg::RORI, aluPkg::SRLI, aluPkg::SHIFTREG: begin
                case (mode)
                    2'b00: begin
                        dbl      = {a, a} << n;
                        r.result = dbl[31:16];
                    end
                    2'b01: r.result = a << n;
                    2'b10: begin
                        dbl      = {a, a} >> n;
                        r.result = dbl[15:0];
                    end
                    default: r.result = a >> n;
                endcase
            end
            aluPkg::BTR: begin
                for (i = 0; i < 16; i++) begin
                    r.result[i] = a[15-i];
                end
            end
            aluPkg::SEQ:  r.result = (a == b) ? 16'd1 : 16'd0;
            aluPkg::SLT:  r.result = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            aluPkg::SLE:  r.result = ($signed(a) <= $signed(b)) ? 16'd1 : 16'd0;
            aluPkg::SCO:  r.result = {15'd0, wide[16]};
            aluPkg::LBI:  r.result = b;
            aluPkg::SLBI: r.result = {a[7:0], 8'h00} | b;
            default:      r.flags.err = 1'b1;
        endcase
        r.flags.zero     = (r.result == '0);
        r.flags.negative = r.result[15] && !r.flags.zero;
        r.flags.positive = !r.flags.zero && !r.flags.negative;
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, got);
            errCount++;
        end
    endtask

    task automatic apbWrite(input apbPkg::addrT addr, input logic [31:0] data,
                            output logic slvErr);
        @(negedge clk);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b1;
        apbReq.paddr   = addr;
        apbReq.pwdata  = data;
        @(negedge clk);
        apbReq.penable = 1'b1;  // Access cycle
        @(posedge clk);
        slvErr = apbResp.pslverr;
        checkValue("pready (write)", 32'(apbResp.pready), 32'd1);
        @(negedge clk);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic apbRead(input apbPkg::addrT addr, output logic [31:0] data,
                           output logic slvErr);
        @(negedge clk);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
        apbReq.paddr   = addr;
        @(negedge clk);
        apbReq.penable = 1'b1;
        @(posedge clk);
        data   = apbResp.prdata;  // Stable since the falling edge
        slvErr = apbResp.pslverr;
        checkValue("pready (read)", 32'(apbResp.pready), 32'd1);
        @(negedge clk);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    // Loads operands and command and polls for done
    task automatic runCommand(input logic [31:0] operands, input logic [31:0] command,
                              output logic [31:0] rd);
        logic slvErr;
        int   polls;
        apbWrite(apbPkg::OPERAND_ADDR, operands, slvErr);
        checkValue("pslverr (operand write)", 32'(slvErr), 32'd0);
        apbWrite(apbPkg::COMMAND_ADDR, command, slvErr);
        checkValue("pslverr (command write)", 32'(slvErr), 32'd0);
        rd    = '0;
        polls = 0;
        while (!rd[apbPkg::RES_DONE_BIT] && polls < PollLimit) begin
            apbRead(apbPkg::RESULT_ADDR, rd, slvErr);
            polls++;
        end
        if (!rd[apbPkg::RES_DONE_BIT]) begin
            $display("Command %h never reported done after %0d reads", command, polls);
            errCount++;
        end
    endtask

    task automatic checkCommand(input aluPkg::wordT a, input aluPkg::wordT b,
                                input logic [31:0] command);
        logic [31:0]     rd;
        aluPkg::aluRespT exp;
        exp = expectedResp(a, b, command[4:0], command[6:5]);
        runCommand({b, a}, command, rd);
        checkValue("result", 32'(rd[15:0]), 32'(exp.result));
        checkValue("zero", 32'(rd[apbPkg::RES_ZERO_BIT]), 32'(exp.flags.zero));
        checkValue("positive", 32'(rd[apbPkg::RES_POS_BIT]), 32'(exp.flags.positive));
        checkValue("negative", 32'(rd[apbPkg::RES_NEG_BIT]), 32'(exp.flags.negative));
        checkValue("err", 32'(rd[apbPkg::RES_ERR_BIT]), 32'(exp.flags.err));
    endtask

    task automatic endTest(input string name);
        if (errCount == testStartErr) begin
            testsPassed++;
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: failed with %0d errors", name, errCount - testStartErr);
        end
        testStartErr = errCount;
    endtask

    initial begin
        logic [31:0]     rd;
        logic [31:0]     word;
        aluPkg::aluRespT expKept;
        logic            slvErr;
        logic [4:0]      op;
        logic [1:0]      fn;
        aluPkg::wordT    cornerA [4];
        aluPkg::wordT    cornerB [4];
        aluPkg::wordT    patterns [4];
        logic [4:0]      cmpOps [4];
        logic [4:0]      shiftOps [4];
        logic [4:0]      idleOps [4];
        int              i;
        int              j;
        seed = 32'hd709_b9ab;
        void'($urandom(seed));
        apbReq       = '0;
        rst          = 1'b1;
        errCount     = 0;
        testsPassed  = 0;
        testsFailed  = 0;
        testStartErr = 0;
        cornerA  = '{16'h7FFF, 16'h8000, 16'hFFFF, 16'h0001};
        cornerB  = '{16'h8000, 16'h7FFF, 16'h0001, 16'hFFFF};
        patterns = '{16'hAAAA, 16'h5555, 16'hCCCC, 16'h3333};
        cmpOps   = '{aluPkg::SLT, aluPkg::SLE, aluPkg::SEQ, aluPkg::SCO};
        shiftOps = '{aluPkg::ROLI, aluPkg::SLLI, aluPkg::RORI, aluPkg::SRLI};
        idleOps  = '{aluPkg::HALT, aluPkg::NOP, aluPkg::SIIC, aluPkg::RTI};
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        apbRead(apbPkg::RESULT_ADDR, rd, slvErr);
        checkValue("prdata (result after reset)", rd, 32'd0);
        checkValue("pslverr (result read)", 32'(slvErr), 32'd0);
        word = $urandom;
        apbWrite(apbPkg::OPERAND_ADDR, word, slvErr);
        apbRead(apbPkg::OPERAND_ADDR, rd, slvErr);
        checkValue("prdata (operand readback)", rd, word);
        endTest("reset and operand readback");

        repeat (RandomCmds) begin
            op = 5'($urandom_range(31, 0));
            fn = 2'($urandom_range(3, 0));
            checkCommand(16'($urandom), 16'($urandom), {25'd0, fn, op});
        end
        endTest("random commands");

        for (i = 0; i < 4; i++) begin
            for (j = 0; j < 4; j++) begin
                checkCommand(cornerA[j], cornerB[j], {27'd0, cmpOps[i]});
            end
        end
        for (i = 0; i < 4; i++) begin
            for (j = 0; j < 2; j++) begin
                checkCommand(16'hB3C5, (j == 0) ? 16'd0 : 16'd15, {27'd0, shiftOps[i]});
                checkCommand(16'hB3C5, (j == 0) ? 16'd0 : 16'd15,
                             {25'd0, 2'(i), aluPkg::SHIFTREG});
            end
        end
        for (i = 0; i < 4; i++) begin
            checkCommand(patterns[i], 16'($urandom), {27'd0, aluPkg::BTR});
        end
        endTest("corner operands");

        // Junk above the funct field must be ignored
        repeat (JunkCmds) begin
            checkCommand(16'($urandom), 16'($urandom), $urandom);
        end
        for (i = 0; i < 4; i++) begin
            checkCommand(16'($urandom), 16'($urandom), {27'd0, idleOps[i]});
        end
        endTest("opcode space and do-nothing group");

        apbRead(12'h010, rd, slvErr);
        checkValue("pslverr (unmapped read)", 32'(slvErr), 32'd1);
        apbWrite(12'hFFC, $urandom, slvErr);
        checkValue("pslverr (unmapped write)", 32'(slvErr), 32'd1);
        apbWrite(apbPkg::RESULT_ADDR, $urandom, slvErr);
        checkValue("pslverr (result write)", 32'(slvErr), 32'd1);
        apbRead(apbPkg::COMMAND_ADDR, rd, slvErr);
        checkValue("pslverr (command read)", 32'(slvErr), 32'd1);
        checkCommand(16'h4321, 16'h1111, {25'd0, aluPkg::FUNCT_SUB, aluPkg::ARITHREG});
        endTest("bus errors");

        expKept = expectedResp(16'h1234, 16'h0101, aluPkg::ADDI, 2'b00);
        checkCommand(16'h1234, 16'h0101, {27'd0, aluPkg::ADDI});
        apbWrite(apbPkg::OPERAND_ADDR, $urandom, slvErr);
        apbRead(apbPkg::RESULT_ADDR, rd, slvErr);
        checkValue("done (after operand write)", 32'(rd[apbPkg::RES_DONE_BIT]), 32'd0);
        checkValue("result fields (after operand write)", 32'(rd[19:0]),
                   32'({expKept.flags.err, expKept.flags.negative, expKept.flags.positive,
                        expKept.flags.zero, expKept.result}));
        endTest("done cleared by operand write");

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 testsPassed, testsFailed, errCount);
        if (testsFailed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
